// ==== src/isaPkg.sv ====
package isaPkg;

   localparam int wordWidth = 16;
   localparam int regIdxWidth = 3;
   localparam int regCount = 8;

   typedef logic [wordWidth-1:0] word_t;
   typedef logic [wordWidth-1:0] pc_t;
   typedef logic [regIdxWidth-1:0] regIdx_t;

   // Primary opcode in the top five bits; any other code is illegal
   typedef enum logic [4:0] {
      opHalt = 5'b00000,
      opNop  = 5'b00001,
      opJ    = 5'b00100,
      opAddi = 5'b01000,
      opBeqz = 5'b01100,
      opSt   = 5'b10000,
      opLd   = 5'b10001,
      opLbi  = 5'b11000,
      opAdd  = 5'b11011,
      opSub  = 5'b11100,
      opAnd  = 5'b11101,
      opXor  = 5'b11110
   } opcode_t;

   // Field positions, immediates all start at bit 0
   localparam int opMsb = 15;
   localparam int opLsb = 11;
   localparam int rsMsb = 10;
   localparam int rsLsb = 8;
   localparam int rtMsb = 7;
   localparam int rtLsb = 5;
   localparam int rdMsb = 4;
   localparam int rdLsb = 2;
   localparam int rdImmMsb = 7;
   localparam int rdImmLsb = 5;
   localparam int imm5Msb = 4;
   localparam int imm8Msb = 7;
   localparam int imm11Msb = 10;

endpackage

// ==== src/pipePkg.sv ====
package pipePkg;

   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluXor,
      aluPassB
   } aluOp_t;

   typedef struct packed {
      logic valid;
      isaPkg::word_t instr;
      isaPkg::pc_t pcNext;
   } fdReg_t;

   typedef struct packed {
      logic valid;
      aluOp_t aluOp;
      isaPkg::word_t opA;
      isaPkg::word_t opB;
      isaPkg::word_t storeData;
      logic isLoad;
      logic isStore;
      logic isBranch;
      logic isJump;
      // Already sign extended
      isaPkg::word_t branchOffset;
      isaPkg::pc_t pcNext;
      logic regWrite;
      isaPkg::regIdx_t dest;
      logic isHalt;
      logic illegal;
   } dxReg_t;

   typedef struct packed {
      logic valid;
      // ALU value, or the address for LD and ST
      isaPkg::word_t result;
      isaPkg::word_t storeData;
      logic isLoad;
      logic isStore;
      logic regWrite;
      isaPkg::regIdx_t dest;
      logic isHalt;
      logic illegal;
   } xmReg_t;

   typedef struct packed {
      logic taken;
      isaPkg::pc_t target;
   } redirect_t;

   typedef struct packed {
      logic valid;
      logic regWrite;
      isaPkg::regIdx_t dest;
      isaPkg::word_t data;
      logic isHalt;
      logic illegal;
   } retire_t;

endpackage

// ==== src/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none
module fetchStage #(
   parameter isaPkg::pc_t resetPc = '0
) (
   input  wire                clk,
   input  wire                rstN,
   input  wire                stall,
   input  pipePkg::redirect_t redirect,
   output isaPkg::pc_t        imemAddr,
   input  isaPkg::word_t      imemData,
   output pipePkg::fdReg_t    fdOut
);

   isaPkg::pc_t pc;
   isaPkg::pc_t pcPlusOne;
   isaPkg::pc_t pcNextSel;

   assign pcPlusOne = pc + 1'b1;
   assign imemAddr = pc;

   // Redirect wins over a stall
   always_comb begin
      if (redirect.taken) begin
         pcNextSel = redirect.target;
      end else if (stall) begin
         pcNextSel = pc;
      end else begin
         pcNextSel = pcPlusOne;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= resetPc;
      end else begin
         pc <= pcNextSel;
      end
   end

   // Fetched word is dropped when the branch in execute is taken
   always_ff @(posedge clk) begin
      if (!rstN) begin
         fdOut.valid <= 1'b0;
      end else if (redirect.taken) begin
         fdOut.valid <= 1'b0;
      end else if (!stall) begin
         fdOut.valid <= 1'b1;
         fdOut.instr <= imemData;
         fdOut.pcNext <= pcPlusOne;
      end
   end

   pcHoldOnStall: assert property (@(posedge clk) disable iff (!rstN)
      (stall && !redirect.taken) |=> $stable(pc));

endmodule
`default_nettype wire

// ==== src/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none
module decodeStage (
   input  wire                clk,
   input  wire                rstN,
   input  pipePkg::fdReg_t    fdIn,
   input  pipePkg::redirect_t redirect,
   input  pipePkg::xmReg_t    xmIn,
   input  pipePkg::retire_t   retire,
   output logic               stall,
   output pipePkg::dxReg_t    dxOut
);

   isaPkg::word_t regs [isaPkg::regCount];
   isaPkg::opcode_t op;
   isaPkg::regIdx_t idxA;
   isaPkg::regIdx_t idxB;
   isaPkg::word_t valA;
   isaPkg::word_t valB;
   logic readsA;
   logic readsB;
   logic hazA;
   logic hazB;
   logic issue;
   logic halted;
   pipePkg::dxReg_t dxNext;

   function automatic isaPkg::word_t signExt(isaPkg::word_t raw, int msb);
      isaPkg::word_t shifted;
      shifted = raw << (isaPkg::wordWidth - 1 - msb);
      return isaPkg::word_t'($signed(shifted) >>> (isaPkg::wordWidth - 1 - msb));
   endfunction

   assign op = isaPkg::opcode_t'(fdIn.instr[isaPkg::opMsb:isaPkg::opLsb]);
   assign idxA = fdIn.instr[isaPkg::rsMsb:isaPkg::rsLsb];
   // ST carries its data register where the register form has rt
   assign idxB = fdIn.instr[isaPkg::rtMsb:isaPkg::rtLsb];

   always_ff @(posedge clk) begin
      if (retire.valid && retire.regWrite) begin
         regs[retire.dest] <= retire.data;
      end
   end

   // Write in the same cycle is bypassed
   assign valA = (retire.valid && retire.regWrite && retire.dest == idxA) ? retire.data
                                                                          : regs[idxA];
   assign valB = (retire.valid && retire.regWrite && retire.dest == idxB) ? retire.data
                                                                          : regs[idxB];

   // Older writers still in execute or memory
   assign hazA = (dxOut.valid && dxOut.regWrite && dxOut.dest == idxA) ||
                 (xmIn.valid && xmIn.regWrite && xmIn.dest == idxA);
   assign hazB = (dxOut.valid && dxOut.regWrite && dxOut.dest == idxB) ||
                 (xmIn.valid && xmIn.regWrite && xmIn.dest == idxB);

   assign stall = fdIn.valid && !halted && ((readsA && hazA) || (readsB && hazB));
   assign issue = fdIn.valid && !halted && !stall && !redirect.taken;

   always_comb begin
      dxNext = '0;
      dxNext.aluOp = pipePkg::aluAdd;
      dxNext.opA = valA;
      dxNext.opB = valB;
      dxNext.storeData = valB;
      dxNext.pcNext = fdIn.pcNext;
      readsA = 1'b0;
      readsB = 1'b0;
      case (op)
         isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd, isaPkg::opXor: begin
            readsA = 1'b1;
            readsB = 1'b1;
            dxNext.regWrite = 1'b1;
            dxNext.dest = fdIn.instr[isaPkg::rdMsb:isaPkg::rdLsb];
            dxNext.aluOp = (op == isaPkg::opSub) ? pipePkg::aluSub :
                           (op == isaPkg::opAnd) ? pipePkg::aluAnd :
                           (op == isaPkg::opXor) ? pipePkg::aluXor : pipePkg::aluAdd;
         end
         isaPkg::opAddi, isaPkg::opLd: begin
            readsA = 1'b1;
            dxNext.opB = signExt(fdIn.instr, isaPkg::imm5Msb);
            dxNext.isLoad = (op == isaPkg::opLd);
            dxNext.regWrite = 1'b1;
            dxNext.dest = fdIn.instr[isaPkg::rdImmMsb:isaPkg::rdImmLsb];
         end
         isaPkg::opSt: begin
            readsA = 1'b1;
            readsB = 1'b1;
            dxNext.opB = signExt(fdIn.instr, isaPkg::imm5Msb);
            dxNext.isStore = 1'b1;
         end
         isaPkg::opLbi: begin
            dxNext.aluOp = pipePkg::aluPassB;
            dxNext.opB = signExt(fdIn.instr, isaPkg::imm8Msb);
            dxNext.regWrite = 1'b1;
            dxNext.dest = idxA;
         end
         isaPkg::opBeqz: begin
            readsA = 1'b1;
            dxNext.isBranch = 1'b1;
            dxNext.branchOffset = signExt(fdIn.instr, isaPkg::imm8Msb);
         end
         isaPkg::opJ: begin
            dxNext.isJump = 1'b1;
            dxNext.branchOffset = signExt(fdIn.instr, isaPkg::imm11Msb);
         end
         isaPkg::opHalt: dxNext.isHalt = 1'b1;
         isaPkg::opNop: ;
         default: dxNext.illegal = 1'b1;
      endcase
   end

   // Only bubbles leave decode once a HALT has gone down the pipe
   always_ff @(posedge clk) begin
      if (!rstN) begin
         halted <= 1'b0;
      end else if (issue && op == isaPkg::opHalt) begin
         halted <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         dxOut.valid <= 1'b0;
      end else begin
         dxOut <= dxNext;
         dxOut.valid <= issue;
      end
   end

   bubbleAfterStall: assert property (@(posedge clk) disable iff (!rstN)
      stall |=> !dxOut.valid);

endmodule
`default_nettype wire

// ==== src/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none
module executeStage (
   input  wire                clk,
   input  wire                rstN,
   input  pipePkg::dxReg_t    dxIn,
   output pipePkg::redirect_t redirect,
   output pipePkg::xmReg_t    xmOut
);

   isaPkg::word_t aluResult;

   // SUB is rs minus rt
   always_comb begin
      case (dxIn.aluOp)
         pipePkg::aluAdd:   aluResult = dxIn.opA + dxIn.opB;
         pipePkg::aluSub:   aluResult = dxIn.opA - dxIn.opB;
         pipePkg::aluAnd:   aluResult = dxIn.opA & dxIn.opB;
         pipePkg::aluXor:   aluResult = dxIn.opA ^ dxIn.opB;
         pipePkg::aluPassB: aluResult = dxIn.opB;
         default:           aluResult = '0;
      endcase
   end

   // Branch resolves here, the two younger stages get flushed
   assign redirect.taken = dxIn.valid &&
                           (dxIn.isJump || (dxIn.isBranch && dxIn.opA == '0));
   assign redirect.target = dxIn.pcNext + dxIn.branchOffset;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         xmOut.valid <= 1'b0;
      end else begin
         xmOut.valid <= dxIn.valid;
         xmOut.result <= aluResult;
         xmOut.storeData <= dxIn.storeData;
         xmOut.isLoad <= dxIn.isLoad;
         xmOut.isStore <= dxIn.isStore;
         xmOut.regWrite <= dxIn.regWrite;
         xmOut.dest <= dxIn.dest;
         xmOut.isHalt <= dxIn.isHalt;
         xmOut.illegal <= dxIn.illegal;
      end
   end

   redirectFromValid: assert property (@(posedge clk) disable iff (!rstN)
      redirect.taken |-> dxIn.valid && (dxIn.isBranch || dxIn.isJump));

endmodule
`default_nettype wire

// ==== src/memoryStage.sv ====
`timescale 1ns/1ps
`default_nettype none
module memoryStage #(
   parameter int dmemWords = 64
) (
   input  wire              clk,
   input  wire              rstN,
   input  pipePkg::xmReg_t  xmIn,
   output pipePkg::retire_t retire,
   output logic             halt,
   output logic             err
);

   localparam int addrBits = $clog2(dmemWords);

   isaPkg::word_t dmem [dmemWords];
   logic [addrBits-1:0] dAddr;
   isaPkg::word_t loadData;

   // Address wraps modulo the memory size
   assign dAddr = xmIn.result[addrBits-1:0];
   assign loadData = dmem[dAddr];

   always_ff @(posedge clk) begin
      if (xmIn.valid && xmIn.isStore) begin
         dmem[dAddr] <= xmIn.storeData;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         retire.valid <= 1'b0;
      end else begin
         retire.valid <= xmIn.valid;
         retire.regWrite <= xmIn.regWrite;
         retire.dest <= xmIn.dest;
         retire.data <= xmIn.isLoad ? loadData : xmIn.result;
         retire.isHalt <= xmIn.isHalt;
         retire.illegal <= xmIn.illegal;
      end
   end

   // Sticky flags rise together with the retire record
   always_ff @(posedge clk) begin
      if (!rstN) begin
         halt <= 1'b0;
         err <= 1'b0;
      end else begin
         if (xmIn.valid && xmIn.isHalt) halt <= 1'b1;
         if (xmIn.valid && xmIn.illegal) err <= 1'b1;
      end
   end

   nothingAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
      halt |=> !retire.valid);

endmodule
`default_nettype wire

// ==== src/cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none
module cpuTop #(
   parameter isaPkg::pc_t resetPc = '0,
   parameter int dmemWords = 64
) (
   input  wire              clk,
   input  wire              rstN,
   output isaPkg::pc_t      imemAddr,
   input  isaPkg::word_t    imemData,
   output pipePkg::retire_t retire,
   output logic             halt,
   output logic             err
);

   logic stall;
   pipePkg::redirect_t redirect;
   pipePkg::fdReg_t fdReg;
   pipePkg::dxReg_t dxReg;
   pipePkg::xmReg_t xmReg;

   fetchStage #(.resetPc(resetPc)) fetchSection (
      .clk(clk),
      .rstN(rstN),
      .stall(stall),
      .redirect(redirect),
      .imemAddr(imemAddr),
      .imemData(imemData),
      .fdOut(fdReg)
   );

   decodeStage decodeSection (
      .clk(clk),
      .rstN(rstN),
      .fdIn(fdReg),
      .redirect(redirect),
      .xmIn(xmReg),
      .retire(retire),
      .stall(stall),
      .dxOut(dxReg)
   );

   executeStage executeSection (
      .clk(clk),
      .rstN(rstN),
      .dxIn(dxReg),
      .redirect(redirect),
      .xmOut(xmReg)
   );

   // Memory access and writeback share this stage
   memoryStage #(.dmemWords(dmemWords)) memorySection (
      .clk(clk),
      .rstN(rstN),
      .xmIn(xmReg),
      .retire(retire),
      .halt(halt),
      .err(err)
   );

endmodule
`default_nettype wire

// ==== tb/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none
module cpuTb;

   localparam isaPkg::pc_t resetPc = '0;
   localparam int dmemWords = 16;
   localparam int romWords = 64;
   localparam int tableWords = 128;
   localparam int maxPrograms = 8;

   logic clk = 1'b0;
   logic rstN = 1'b0;
   isaPkg::pc_t imemAddr;
   isaPkg::word_t imemData;
   pipePkg::retire_t retire;
   logic halt;
   logic err;

   // Program table with one row of words per program
   isaPkg::word_t progTable [tableWords];
   int progStart [maxPrograms];
   int progLen [maxPrograms];
   int progCount = 0;
   int tableFill = 0;

   isaPkg::word_t rom [romWords];
   isaPkg::word_t modelRegs [isaPkg::regCount];
   isaPkg::word_t modelMem [dmemWords];
   isaPkg::regIdx_t expDest [$];
   isaPkg::word_t expData [$];
   logic expHalt;
   logic expErr;
   logic seenHalt;
   int valueErrors = 0;
   int otherErrors = 0;
   int runCycles = 0;
   int cycleLimit = 0;

   always #50 clk = ~clk;

   // Instruction ROM answers in the same cycle
   assign imemData = rom[imemAddr[5:0]];

   cpuTop #(.resetPc(resetPc), .dmemWords(dmemWords)) UUT (
      .clk(clk),
      .rstN(rstN),
      .imemAddr(imemAddr),
      .imemData(imemData),
      .retire(retire),
      .halt(halt),
      .err(err)
   );

   function automatic isaPkg::word_t encReg(isaPkg::opcode_t op, isaPkg::regIdx_t rd,
         isaPkg::regIdx_t rs, isaPkg::regIdx_t rt);
      return {op, rs, rt, rd, 2'b00};
   endfunction

   // Also used by ST, where rd names the data register
   function automatic isaPkg::word_t encImm(isaPkg::opcode_t op, isaPkg::regIdx_t rd,
         isaPkg::regIdx_t rs, logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic isaPkg::word_t encLbi(isaPkg::regIdx_t rd, logic [7:0] imm);
      return {isaPkg::opLbi, rd, imm};
   endfunction

   function automatic isaPkg::word_t encBeqz(isaPkg::regIdx_t rs, logic [7:0] imm);
      return {isaPkg::opBeqz, rs, imm};
   endfunction

   function automatic isaPkg::word_t encJ(logic [10:0] imm);
      return {isaPkg::opJ, imm};
   endfunction

   function automatic isaPkg::word_t encHalt();
      return {isaPkg::opHalt, 11'd0};
   endfunction

   task automatic addWord(isaPkg::word_t w);
      progTable[tableFill] = w;
      tableFill++;
   endtask

   task automatic beginProgram();
      progStart[progCount] = tableFill;
   endtask

   task automatic endProgram();
      progLen[progCount] = tableFill - progStart[progCount];
      progCount++;
   endtask

   task automatic buildTable();
      int kind;
      isaPkg::regIdx_t rd;
      isaPkg::regIdx_t rs;
      isaPkg::regIdx_t rt;
      // Dependent arithmetic chain
      beginProgram();
      addWord(encLbi(3'd1, 8'd5));
      addWord(encLbi(3'd2, 8'hFD));
      addWord(encReg(isaPkg::opAdd, 3'd3, 3'd1, 3'd2));
      addWord(encReg(isaPkg::opSub, 3'd4, 3'd3, 3'd1));
      addWord(encReg(isaPkg::opAnd, 3'd5, 3'd4, 3'd3));
      addWord(encReg(isaPkg::opXor, 3'd6, 3'd5, 3'd4));
      addWord(encImm(isaPkg::opAddi, 3'd7, 3'd6, 5'd7));
      addWord(encImm(isaPkg::opAddi, 3'd7, 3'd7, 5'h1F));
      addWord(encLbi(3'd0, 8'h7F));
      addWord(encReg(isaPkg::opAdd, 3'd0, 3'd0, 3'd7));
      addWord(encHalt());
      endProgram();
      // Stores and loads where r5 holds an address past the end of data memory
      beginProgram();
      addWord(encLbi(3'd1, 8'd4));
      addWord(encLbi(3'd2, 8'h55));
      addWord(encImm(isaPkg::opSt, 3'd2, 3'd1, 5'd0));
      addWord(encImm(isaPkg::opSt, 3'd1, 3'd1, 5'd3));
      addWord(encImm(isaPkg::opLd, 3'd3, 3'd1, 5'd0));
      addWord(encImm(isaPkg::opLd, 3'd4, 3'd1, 5'd3));
      addWord(encLbi(3'd5, 8'd20));
      addWord(encImm(isaPkg::opLd, 3'd6, 3'd5, 5'd0));
      addWord(encImm(isaPkg::opSt, 3'd4, 3'd5, 5'h1E));
      addWord(encImm(isaPkg::opLd, 3'd7, 3'd1, 5'h1E));
      addWord(encReg(isaPkg::opAdd, 3'd0, 3'd6, 3'd7));
      addWord(encHalt());
      endProgram();
      // Branches with the LBI r3 and LBI r5 words in taken shadows
      beginProgram();
      addWord(encLbi(3'd1, 8'd0));
      addWord(encLbi(3'd2, 8'd9));
      addWord(encBeqz(3'd1, 8'd2));
      addWord(encLbi(3'd3, 8'd1));
      addWord(encLbi(3'd3, 8'd2));
      addWord(encBeqz(3'd2, 8'd3));
      addWord(encImm(isaPkg::opAddi, 3'd4, 3'd2, 5'd1));
      addWord(encJ(11'd3));
      addWord(encLbi(3'd5, 8'd1));
      addWord(encJ(11'd4));
      addWord(encLbi(3'd5, 8'd2));
      addWord(encImm(isaPkg::opAddi, 3'd6, 3'd4, 5'd5));
      addWord(encJ(11'h7FC));
      addWord(encLbi(3'd5, 8'd3));
      addWord(encReg(isaPkg::opXor, 3'd7, 3'd6, 3'd4));
      addWord(encHalt());
      endProgram();
      // Instructions after HALT never retire
      beginProgram();
      addWord(encLbi(3'd1, 8'd1));
      addWord(encImm(isaPkg::opAddi, 3'd2, 3'd1, 5'd2));
      addWord(encHalt());
      addWord(encLbi(3'd3, 8'd7));
      addWord(encImm(isaPkg::opAddi, 3'd1, 3'd1, 5'd1));
      addWord(encLbi(3'd4, 8'd9));
      endProgram();
      // Two undefined opcodes between legal work
      beginProgram();
      addWord(encLbi(3'd1, 8'd3));
      addWord(16'h12E4);
      addWord(encImm(isaPkg::opAddi, 3'd2, 3'd1, 5'd4));
      addWord(16'hF8A5);
      addWord(encReg(isaPkg::opXor, 3'd3, 3'd2, 3'd1));
      addWord(encHalt());
      endProgram();
      // Random ALU program that loads all registers first
      beginProgram();
      for (int i = 0; i < isaPkg::regCount; i++) begin
         addWord(encLbi(isaPkg::regIdx_t'(i), 8'($urandom)));
      end
      for (int i = 0; i < 20; i++) begin
         kind = $urandom % 6;
         rd = 3'($urandom);
         rs = 3'($urandom);
         rt = 3'($urandom);
         case (kind)
            0: addWord(encReg(isaPkg::opAdd, rd, rs, rt));
            1: addWord(encReg(isaPkg::opSub, rd, rs, rt));
            2: addWord(encReg(isaPkg::opAnd, rd, rs, rt));
            3: addWord(encReg(isaPkg::opXor, rd, rs, rt));
            4: addWord(encImm(isaPkg::opAddi, rd, rs, 5'($urandom)));
            default: addWord(encLbi(rd, 8'($urandom)));
         endcase
      end
      addWord(encHalt());
      endProgram();
   endtask

   // Unused words are NOPs tagged with their own address
   task automatic loadRom(int start, int len);
      for (int i = 0; i < romWords; i++) begin
         if (i < len) begin
            rom[i] = progTable[start + i];
         end else begin
            rom[i] = {isaPkg::opNop, 5'd0, 6'(i)};
         end
      end
   endtask

   task automatic recordWrite(isaPkg::regIdx_t dest, isaPkg::word_t value);
      modelRegs[dest] = value;
      expDest.push_back(dest);
      expData.push_back(value);
   endtask

   // Executes the ROM one instruction at a time by the ISA rules
   task automatic runModel();
      isaPkg::pc_t pc;
      isaPkg::word_t ins;
      isaPkg::word_t a;
      isaPkg::word_t b;
      isaPkg::word_t imm5;
      isaPkg::word_t imm8;
      isaPkg::word_t imm11;
      int steps;
      pc = resetPc;
      steps = 0;
      expHalt = 1'b0;
      expErr = 1'b0;
      expDest.delete();
      expData.delete();
      while (!expHalt && steps < 200) begin
         ins = rom[pc[5:0]];
         pc = pc + 16'd1;
         steps++;
         a = modelRegs[ins[10:8]];
         b = modelRegs[ins[7:5]];
         imm5 = {{11{ins[4]}}, ins[4:0]};
         imm8 = {{8{ins[7]}}, ins[7:0]};
         imm11 = {{5{ins[10]}}, ins[10:0]};
         case (ins[15:11])
            isaPkg::opAdd:  recordWrite(ins[4:2], a + b);
            isaPkg::opSub:  recordWrite(ins[4:2], a - b);
            isaPkg::opAnd:  recordWrite(ins[4:2], a & b);
            isaPkg::opXor:  recordWrite(ins[4:2], a ^ b);
            isaPkg::opAddi: recordWrite(ins[7:5], a + imm5);
            isaPkg::opLbi:  recordWrite(ins[10:8], imm8);
            isaPkg::opLd:   recordWrite(ins[7:5], modelMem[int'(a + imm5) % dmemWords]);
            isaPkg::opSt:   modelMem[int'(a + imm5) % dmemWords] = b;
            isaPkg::opBeqz: if (a == 16'd0) pc = pc + imm8;
            isaPkg::opJ:    pc = pc + imm11;
            isaPkg::opHalt: expHalt = 1'b1;
            isaPkg::opNop:  ;
            default:        expErr = 1'b1;
         endcase
      end
   endtask

   task automatic checkRetire();
      isaPkg::regIdx_t wantDest;
      isaPkg::word_t wantData;
      if (retire.valid && seenHalt) begin
         $display("%0t ns: an instruction retired after the HALT", $time);
         otherErrors++;
      end else if (retire.valid && retire.isHalt) begin
         seenHalt = 1'b1;
         if (expDest.size() != 0) begin
            $display("%0t ns: HALT retired early, %0d register writes still expected",
                     $time, expDest.size());
            otherErrors++;
         end
      end else if (retire.valid && retire.illegal && retire.regWrite) begin
         $display("%0t ns: an illegal instruction wrote r%0d", $time, retire.dest);
         otherErrors++;
      end else if (retire.valid && retire.regWrite) begin
         if (expDest.size() == 0) begin
            $display("%0t ns: unexpected write of r%0d retired", $time, retire.dest);
            otherErrors++;
         end else begin
            wantDest = expDest.pop_front();
            wantData = expData.pop_front();
            if (retire.dest !== wantDest) begin
               $display("[ERROR] %0t ns retire.dest expected %0d got %0d",
                        $time, wantDest, retire.dest);
               valueErrors++;
            end
            if (retire.data !== wantData) begin
               $display("[ERROR] %0t ns retire.data expected %h got %h",
                        $time, wantData, retire.data);
               valueErrors++;
            end
         end
      end
      if (retire.valid && retire.illegal && err !== 1'b1) begin
         $display("[ERROR] %0t ns err expected 1 got %b", $time, err);
         valueErrors++;
      end
      if (seenHalt && halt !== 1'b1) begin
         $display("%0t ns: halt fell after the HALT retired", $time);
         otherErrors++;
      end
      if (!seenHalt && halt === 1'b1) begin
         $display("%0t ns: halt rose without a retired HALT", $time);
         otherErrors++;
      end
   endtask

   task automatic runProgram(int p);
      int postHalt;
      @(negedge clk);
      rstN = 1'b0;
      loadRom(progStart[p], progLen[p]);
      runModel();
      seenHalt = 1'b0;
      repeat (10) @(negedge clk);
      rstN = 1'b1;
      postHalt = 0;
      // One check per cycle on the falling edge
      while (postHalt < 5) begin
         @(negedge clk);
         runCycles++;
         checkRetire();
         if (seenHalt) postHalt++;
      end
      if (expDest.size() != 0) begin
         $display("Program %0d: %0d expected register writes never retired",
                  p, expDest.size());
         otherErrors++;
      end
      if (err !== expErr) begin
         $display("[ERROR] %0t ns err expected %b got %b", $time, expErr, err);
         valueErrors++;
      end
      if (halt !== expHalt) begin
         $display("[ERROR] %0t ns halt expected %b got %b", $time, expHalt, halt);
         valueErrors++;
      end
   endtask

   always @(posedge clk) begin
      if (runCycles > cycleLimit) begin
         $display("Timeout: the programs did not finish within %0d cycles", cycleLimit);
         $display("Errors: %0d value, %0d other", valueErrors, otherErrors);
         $display("Simulation FAILED");
         $finish;
      end
   end

   initial begin
      int limit;
      void'($urandom(63));
      for (int i = 0; i < isaPkg::regCount; i++) begin
         modelRegs[i] = '0;
      end
      buildTable();
      limit = 0;
      for (int p = 0; p < progCount; p++) begin
         limit = limit + 8 * progLen[p] + 20;
      end
      cycleLimit = limit;
      for (int p = 0; p < progCount; p++) begin
         runProgram(p);
      end
      $display("Errors: %0d value, %0d other", valueErrors, otherErrors);
      if (valueErrors + otherErrors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule
`default_nettype wire

// ==== files.f ====
src/isaPkg.sv
src/pipePkg.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/cpuTop.sv
tb/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f files.f -o cpuSim &&
   ./obj_dir/cpuSim > sim.log 2>&1 ||
   echo "run.sh: build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "^Simulation PASSED$" sim.log && echo "run.sh: pass" && exit 0 ||
   { echo "run.sh: fail"; exit 1; }
